// ==== Makefile ====
TOP := l1_trigger_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f verilog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) -o $(TOP)
	@out="$$(./obj_dir/$(TOP) 2>&1)"; echo "$$out"; echo "$$out" | grep -qF '>>> PASS'

clean:
	rm -rf obj_dir

// ==== logic/adc_unpack.sv ====
`timescale 1ns/1ps

module adc_unpack (
    input  logic                                              aclk,
    input  logic                                              arst_n_i,
    input  l1_trig_pkg::lane_word_t [l1_trig_pkg::NCHAN-1:0]  adc_tdata_i,
    input  logic [l1_trig_pkg::NCHAN-1:0]                     adc_tvalid_i,
    output l1_trig_pkg::adc_frame_t                           frame_o
);
    import l1_trig_pkg::*;

    logic                    valid_q;
    sample_vec_t [NCHAN-1:0] chan_q;
    logic                    accept;

    // Drop the low nibble of every lane
    function automatic sample_vec_t strip_lanes(lane_word_t word);
        sample_vec_t vec;
        for (int i = 0; i < NSAMP; i++) begin
            vec[SAMP_W*i +: SAMP_W] = word[LANE_W*i + (LANE_W-SAMP_W) +: SAMP_W];
        end
        return vec;
    endfunction

    // No tready, so a word is taken only when every stream offers one
    assign accept = &adc_tvalid_i;

    always_ff @(posedge aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= accept;
        end
    end

    // Sample registers hold their last frame when nothing is accepted
    always_ff @(posedge aclk) begin
        if (accept) begin
            for (int c = 0; c < NCHAN; c++) begin
                chan_q[c] <= strip_lanes(adc_tdata_i[c]);
            end
        end
    end

    assign frame_o.valid = valid_q;
    assign frame_o.chan  = chan_q;

    // A valid frame must come from a cycle where all four streams were valid
    a_frame_from_all_valid : assert property (
        @(posedge aclk) disable iff (!arst_n_i)
        $rose(frame_o.valid) |-> $past(&adc_tvalid_i)
    );

endmodule

// ==== logic/beam_power.sv ====
`timescale 1ns/1ps

module beam_power (
    input  logic                      aclk,
    input  logic                      arst_n_i,
    input  l1_trig_pkg::adc_frame_t   frame_i,
    output l1_trig_pkg::power_frame_t power_o
);
    import l1_trig_pkg::*;

    // Stage one, pair sums
    logic                                 valid1_q;
    beam_sum_t [NBEAMS-1:0][NSAMP-1:0]    sum_q;
    sample_vec_t                          chan0_1_q;

    // Stage two, beam power
    logic                 valid2_q;
    power_t [NBEAMS-1:0]  power_d;
    power_t [NBEAMS-1:0]  power_q;
    sample_vec_t          chan0_2_q;

    function automatic sample_t get_sample(sample_vec_t vec, int idx);
        return vec[SAMP_W*idx +: SAMP_W];
    endfunction

    // Widen before the add so the sign is kept
    function automatic beam_sum_t pair_sum(sample_t a, sample_t b);
        return beam_sum_t'(a) + beam_sum_t'(b);
    endfunction

    // Widen to 16 bits first, -4096 has no positive twin in 13 bits
    function automatic power_t abs_val(beam_sum_t s);
        logic signed [15:0] wide;
        wide = 16'(s);
        return s[SAMP_W] ? power_t'(-wide) : power_t'(wide);
    endfunction

    always_ff @(posedge aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid1_q <= 1'b0;
            valid2_q <= 1'b0;
        end else begin
            valid1_q <= frame_i.valid;
            valid2_q <= valid1_q;
        end
    end

    // Beam b pairs channels 2b and 2b+1
    always_ff @(posedge aclk) begin
        for (int b = 0; b < NBEAMS; b++) begin
            for (int i = 0; i < NSAMP; i++) begin
                sum_q[b][i] <= pair_sum(get_sample(frame_i.chan[2*b], i),
                                        get_sample(frame_i.chan[2*b+1], i));
            end
        end
        chan0_1_q <= frame_i.chan[0];
        power_q   <= power_d;
        chan0_2_q <= chan0_1_q;
    end

    // Sum of magnitudes per beam
    always_comb begin
        for (int b = 0; b < NBEAMS; b++) begin
            power_d[b] = '0;
            for (int i = 0; i < NSAMP; i++) begin
                power_d[b] = power_d[b] + abs_val(sum_q[b][i]);
            end
        end
    end

    assign power_o.valid = valid2_q;
    assign power_o.power = power_q;
    assign power_o.chan0 = chan0_2_q;

    // Eight magnitudes of at most 4096 cap a valid beam power at 32768
    a_power_in_range : assert property (
        @(posedge aclk) disable iff (!arst_n_i)
        power_o.valid |-> (power_o.power[0] <= 16'd32768) && (power_o.power[1] <= 16'd32768)
    );

endmodule

// ==== logic/l1_trig_pkg.sv ====
package l1_trig_pkg;

    // Receiver geometry
    localparam int NCHAN  = 4;
    localparam int NBEAMS = 2;
    localparam int NSAMP  = 8;
    localparam int SAMP_W = 12;
    localparam int LANE_W = 16;

    // Raw AXI4-Stream word, eight lanes with the sample in the top 12 bits
    typedef logic [NSAMP*LANE_W-1:0] lane_word_t;
    typedef logic signed [SAMP_W-1:0] sample_t;
    typedef logic [NSAMP*SAMP_W-1:0] sample_vec_t;

    // One extra bit so a channel pair sum cannot wrap
    typedef logic signed [SAMP_W:0] beam_sum_t;

    // Eight magnitudes of at most 4096 each, so 32768 tops out the power
    typedef logic [15:0] power_t;
    typedef logic [15:0] count_t;

    // Control port
    typedef logic [1:0]  reg_addr_t;
    typedef logic [15:0] reg_data_t;

    localparam reg_addr_t REG_THRESH0 = 2'd0;
    localparam reg_addr_t REG_THRESH1 = 2'd1;
    localparam reg_addr_t REG_COUNT0  = 2'd2;
    localparam reg_addr_t REG_COUNT1  = 2'd3;

    // Above any reachable power, so nothing fires out of reset
    localparam power_t THRESH_RESET = 16'hffff;
    localparam count_t COUNT_MAX    = 16'hffff;

    // Unpacked samples of all channels for one clock
    typedef struct packed {
        logic                    valid;
        sample_vec_t [NCHAN-1:0] chan;
    } adc_frame_t;

    // Per-beam power, channel 0 rides along for the buffer output
    typedef struct packed {
        logic                 valid;
        power_t [NBEAMS-1:0]  power;
        sample_vec_t          chan0;
    } power_frame_t;

endpackage

// ==== logic/l1_trigger_top.sv ====
`timescale 1ns/1ps

module l1_trigger_top (
    input  logic                                   aclk,
    input  logic                                   arst_n_i,
    // ADC streams
    input  l1_trig_pkg::lane_word_t                adc0_tdata_i,
    input  logic                                   adc0_tvalid_i,
    input  l1_trig_pkg::lane_word_t                adc1_tdata_i,
    input  logic                                   adc1_tvalid_i,
    input  l1_trig_pkg::lane_word_t                adc2_tdata_i,
    input  logic                                   adc2_tvalid_i,
    input  l1_trig_pkg::lane_word_t                adc3_tdata_i,
    input  logic                                   adc3_tvalid_i,
    // Control port
    input  logic                                   req_i,
    input  logic                                   we_i,
    input  l1_trig_pkg::reg_addr_t                 addr_i,
    input  l1_trig_pkg::reg_data_t                 wdata_i,
    output logic                                   ack_o,
    output l1_trig_pkg::reg_data_t                 rdata_o,
    // Results
    output logic [l1_trig_pkg::NBEAMS-1:0]         trig_o,
    output l1_trig_pkg::lane_word_t                buf0_tdata_o,
    output logic                                   buf0_tvalid_o
);
    import l1_trig_pkg::*;

    lane_word_t [NCHAN-1:0] adc_tdata;
    logic [NCHAN-1:0]       adc_tvalid;
    adc_frame_t             adc_frame;
    power_frame_t           power_frame;
    power_t [NBEAMS-1:0]    thresh;
    logic [NBEAMS-1:0]      clear;
    count_t [NBEAMS-1:0]    count;

    // Channel index follows the port number
    assign adc_tdata  = {adc3_tdata_i, adc2_tdata_i, adc1_tdata_i, adc0_tdata_i};
    assign adc_tvalid = {adc3_tvalid_i, adc2_tvalid_i, adc1_tvalid_i, adc0_tvalid_i};

    adc_unpack adc_unpack_inst (
        .aclk         (aclk),
        .arst_n_i     (arst_n_i),
        .adc_tdata_i  (adc_tdata),
        .adc_tvalid_i (adc_tvalid),
        .frame_o      (adc_frame)
    );

    beam_power beam_power_inst (
        .aclk     (aclk),
        .arst_n_i (arst_n_i),
        .frame_i  (adc_frame),
        .power_o  (power_frame)
    );

    trigger_result trigger_result_inst (
        .aclk          (aclk),
        .arst_n_i      (arst_n_i),
        .power_i       (power_frame),
        .thresh_i      (thresh),
        .clear_i       (clear),
        .trig_o        (trig_o),
        .buf0_tdata_o  (buf0_tdata_o),
        .buf0_tvalid_o (buf0_tvalid_o),
        .count_o       (count)
    );

    // Thresholds out, counts back in
    trig_ctrl_regs trig_ctrl_regs_inst (
        .aclk     (aclk),
        .arst_n_i (arst_n_i),
        .req_i    (req_i),
        .we_i     (we_i),
        .addr_i   (addr_i),
        .wdata_i  (wdata_i),
        .ack_o    (ack_o),
        .rdata_o  (rdata_o),
        .thresh_o (thresh),
        .clear_o  (clear),
        .count_i  (count)
    );

endmodule

// ==== logic/trig_ctrl_regs.sv ====
`timescale 1ns/1ps

module trig_ctrl_regs (
    input  logic                                            aclk,
    input  logic                                            arst_n_i,
    input  logic                                            req_i,
    input  logic                                            we_i,
    input  l1_trig_pkg::reg_addr_t                          addr_i,
    input  l1_trig_pkg::reg_data_t                          wdata_i,
    output logic                                            ack_o,
    output l1_trig_pkg::reg_data_t                          rdata_o,
    output l1_trig_pkg::power_t [l1_trig_pkg::NBEAMS-1:0]   thresh_o,
    output logic [l1_trig_pkg::NBEAMS-1:0]                  clear_o,
    input  l1_trig_pkg::count_t [l1_trig_pkg::NBEAMS-1:0]   count_i
);
    import l1_trig_pkg::*;

    typedef enum logic [1:0] {IDLE, ACK, WAIT_DROP} state_t;

    state_t              state_q;
    power_t [NBEAMS-1:0] thresh_q;
    logic [NBEAMS-1:0]   clear_q;
    reg_data_t           rdata_q;
    logic                start;

    // The access happens on the edge that leaves IDLE
    assign start = (state_q == IDLE) && req_i;

    always_ff @(posedge aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q  <= IDLE;
            thresh_q <= {NBEAMS{THRESH_RESET}};
            clear_q  <= '0;
        end else begin
            // Clear is a single-cycle strobe
            clear_q <= '0;
            case (state_q)
                IDLE: begin
                    if (req_i) begin
                        state_q <= ACK;
                        if (we_i) begin
                            case (addr_i)
                                REG_THRESH0: thresh_q[0] <= wdata_i;
                                REG_THRESH1: thresh_q[1] <= wdata_i;
                                REG_COUNT0:  clear_q[0]  <= 1'b1;
                                REG_COUNT1:  clear_q[1]  <= 1'b1;
                            endcase
                        end
                    end
                end
                ACK:       state_q <= req_i ? WAIT_DROP : IDLE;
                WAIT_DROP: if (!req_i) state_q <= IDLE;
                default:   state_q <= IDLE;
            endcase
        end
    end

    // Read data latched once and held for the whole ack phase
    always_ff @(posedge aclk) begin
        if (start) begin
            case (addr_i)
                REG_THRESH0: rdata_q <= thresh_q[0];
                REG_THRESH1: rdata_q <= thresh_q[1];
                REG_COUNT0:  rdata_q <= count_i[0];
                REG_COUNT1:  rdata_q <= count_i[1];
            endcase
        end
    end

    assign ack_o    = (state_q != IDLE);
    assign rdata_o  = rdata_q;
    assign thresh_o = thresh_q;
    assign clear_o  = clear_q;

    // Ack only rises after a cycle with req high
    a_ack_needs_req : assert property (
        @(posedge aclk) disable iff (!arst_n_i)
        $rose(ack_o) |-> $past(req_i)
    );

endmodule

// ==== logic/trigger_result.sv ====
`timescale 1ns/1ps

module trigger_result (
    input  logic                                            aclk,
    input  logic                                            arst_n_i,
    input  l1_trig_pkg::power_frame_t                       power_i,
    input  l1_trig_pkg::power_t [l1_trig_pkg::NBEAMS-1:0]   thresh_i,
    input  logic [l1_trig_pkg::NBEAMS-1:0]                  clear_i,
    output logic [l1_trig_pkg::NBEAMS-1:0]                  trig_o,
    output l1_trig_pkg::lane_word_t                         buf0_tdata_o,
    output logic                                            buf0_tvalid_o,
    output l1_trig_pkg::count_t [l1_trig_pkg::NBEAMS-1:0]   count_o
);
    import l1_trig_pkg::*;

    logic [NBEAMS-1:0]   trig_q;
    logic                tvalid_q;
    lane_word_t          tdata_q;
    count_t [NBEAMS-1:0] count_q;

    // Back to left-aligned lanes, low nibble zero
    function automatic lane_word_t pack_lanes(sample_vec_t vec);
        lane_word_t word;
        for (int i = 0; i < NSAMP; i++) begin
            word[LANE_W*i +: LANE_W] = {vec[SAMP_W*i +: SAMP_W], {(LANE_W-SAMP_W){1'b0}}};
        end
        return word;
    endfunction

    always_ff @(posedge aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            trig_q   <= '0;
            tvalid_q <= 1'b0;
            count_q  <= '0;
        end else begin
            tvalid_q <= power_i.valid;
            for (int b = 0; b < NBEAMS; b++) begin
                // Strictly above, equal power does not fire
                trig_q[b] <= power_i.valid && (power_i.power[b] > thresh_i[b]);
                // Clear wins over a trigger in the same cycle
                if (clear_i[b]) begin
                    count_q[b] <= '0;
                end else if (trig_q[b] && count_q[b] != COUNT_MAX) begin
                    count_q[b] <= count_q[b] + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (power_i.valid) begin
            tdata_q <= pack_lanes(power_i.chan0);
        end
    end

    assign trig_o        = trig_q;
    assign buf0_tdata_o  = tdata_q;
    assign buf0_tvalid_o = tvalid_q;
    assign count_o       = count_q;

    // Trigger only ever follows a valid power frame
    a_trig_needs_valid : assert property (
        @(posedge aclk) disable iff (!arst_n_i)
        (|trig_o) |-> $past(power_i.valid)
    );

endmodule

// ==== verif/l1_trigger_tb.sv ====
`timescale 1ns/1ps

module l1_trigger_tb;
    import l1_trig_pkg::*;

    typedef lane_word_t [3:0] adc_words_t;

    localparam int NUM_WORDS = 64;
    // Two full bursts and the short ones, thirteen register accesses and the drains
    localparam int TIMEOUT_CYCLES = 2 * (3 * NUM_WORDS + 13 * 10 + 6 * 5 + 40);

    logic       aclk;
    logic       arst_n;
    adc_words_t adc_tdata;
    logic [3:0] adc_tvalid;
    logic       req;
    logic       we;
    reg_addr_t  addr;
    reg_data_t  wdata;
    logic       ack_o;
    reg_data_t  rdata_o;
    logic [1:0] trig_o;
    lane_word_t buf0_tdata_o;
    logic       buf0_tvalid_o;

    // Expected outputs, entry 3 is due at the current edge
    logic       exp_valid [4];
    logic [1:0] exp_trig [4];
    lane_word_t exp_buf [4];
    int         model_count [2];
    power_t     model_thresh [2];
    logic [31:0] lfsr_state = 32'hb01d_6746;
    int         cycle_cnt = 0;

    l1_trigger_top l1_trigger_top_inst (
        .aclk          (aclk),
        .arst_n_i      (arst_n),
        .adc0_tdata_i  (adc_tdata[0]),
        .adc0_tvalid_i (adc_tvalid[0]),
        .adc1_tdata_i  (adc_tdata[1]),
        .adc1_tvalid_i (adc_tvalid[1]),
        .adc2_tdata_i  (adc_tdata[2]),
        .adc2_tvalid_i (adc_tvalid[2]),
        .adc3_tdata_i  (adc_tdata[3]),
        .adc3_tvalid_i (adc_tvalid[3]),
        .req_i         (req),
        .we_i          (we),
        .addr_i        (addr),
        .wdata_i       (wdata),
        .ack_o         (ack_o),
        .rdata_o       (rdata_o),
        .trig_o        (trig_o),
        .buf0_tdata_o  (buf0_tdata_o),
        .buf0_tvalid_o (buf0_tvalid_o)
    );

    initial begin
        aclk = 1'b0;
        forever #5 aclk = ~aclk;
    end

    // Stuck run guard
    always @(posedge aclk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display(">>> FAIL");
            $fatal(1);
        end
    end

    // Taps 32, 22, 2, 1
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    // Low nibbles random too, so stripping gets exercised
    function automatic adc_words_t random_words();
        adc_words_t w;
        for (int c = 0; c < 4; c++) begin
            for (int i = 0; i < 128; i++) begin
                w[c][i] = lfsr_step();
            end
        end
        return w;
    endfunction

    // Sample sits in the top 12 bits of its 16-bit lane
    function automatic int sample_of(lane_word_t word, int lane);
        logic signed [11:0] s;
        s = word[16*lane+4 +: 12];
        return int'(s);
    endfunction

    function automatic int magnitude(int v);
        return (v < 0) ? -v : v;
    endfunction

    // Beam b sums channels 2b and 2b+1
    function automatic int model_power(adc_words_t w, int b);
        int p;
        p = 0;
        for (int i = 0; i < 8; i++) begin
            p += magnitude(sample_of(w[2*b], i) + sample_of(w[2*b+1], i));
        end
        return p;
    endfunction

    function automatic lane_word_t repack_chan0(lane_word_t w);
        return w & {8{16'hfff0}};
    endfunction

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
            $display(">>> FAIL");
            $fatal(1);
        end
    endtask

    // One clock: check the result due now, then drive the next word
    task automatic step_cycle(input logic [3:0] valid, input adc_words_t words);
        logic [1:0] trig;
        @(posedge aclk);
        #1;
        check_value("buf0_tvalid_o", 128'(buf0_tvalid_o), 128'(exp_valid[3]));
        check_value("trig_o", 128'(trig_o), 128'(exp_trig[3]));
        if (exp_valid[3]) begin
            check_value("buf0_tdata_o", buf0_tdata_o, exp_buf[3]);
        end
        for (int b = 0; b < 2; b++) begin
            if (exp_trig[3][b]) model_count[b]++;
        end
        for (int s = 3; s > 0; s--) begin
            exp_valid[s] = exp_valid[s-1];
            exp_trig[s]  = exp_trig[s-1];
            exp_buf[s]   = exp_buf[s-1];
        end
        // Strict compare, equal power stays quiet
        for (int b = 0; b < 2; b++) begin
            trig[b] = (&valid) && (model_power(words, b) > int'(model_thresh[b]));
        end
        exp_valid[0] = &valid;
        exp_trig[0]  = trig;
        exp_buf[0]   = repack_chan0(words[0]);
        adc_tdata    = words;
        adc_tvalid   = valid;
    endtask

    task automatic drain_pipe();
        repeat (5) step_cycle(4'h0, '0);
    endtask

    // Four-phase access, req held for hold extra cycles after ack
    task automatic reg_access(input logic wr, input reg_addr_t a, input reg_data_t d,
                              input int hold, output reg_data_t rd);
        @(posedge aclk);
        #1;
        check_value("ack_o", 128'(ack_o), 128'(1'b0));
        req   = 1'b1;
        we    = wr;
        addr  = a;
        wdata = d;
        @(posedge aclk);
        #1;
        while (!ack_o) begin
            @(posedge aclk);
            #1;
        end
        rd = rdata_o;
        repeat (hold) begin
            @(posedge aclk);
            #1;
            check_value("ack_o", 128'(ack_o), 128'(1'b1));
        end
        req = 1'b0;
        we  = 1'b0;
        // Ack drops one cycle after req
        @(posedge aclk);
        #1;
        check_value("ack_o", 128'(ack_o), 128'(1'b0));
    endtask

    task automatic reg_write(input reg_addr_t a, input reg_data_t d, input int hold);
        reg_data_t rd;
        reg_access(1'b1, a, d, hold, rd);
        if (a == 2'd0) model_thresh[0] = d;
        if (a == 2'd1) model_thresh[1] = d;
        if (a == 2'd2) model_count[0] = 0;
        if (a == 2'd3) model_count[1] = 0;
    endtask

    task automatic reg_read(input reg_addr_t a, output reg_data_t rd);
        reg_access(1'b0, a, '0, 0, rd);
    endtask

    task automatic check_after_reset();
        reg_data_t rd;
        check_value("trig_o", 128'(trig_o), 128'(2'b00));
        check_value("buf0_tvalid_o", 128'(buf0_tvalid_o), 128'(1'b0));
        reg_read(2'd0, rd);
        check_value("thresh0", 128'(rd), 128'(16'hffff));
        reg_read(2'd1, rd);
        check_value("thresh1", 128'(rd), 128'(16'hffff));
        reg_read(2'd2, rd);
        check_value("count0", 128'(rd), 128'(16'h0000));
        reg_read(2'd3, rd);
        check_value("count1", 128'(rd), 128'(16'h0000));
        repeat (16) step_cycle(4'hf, random_words());
        drain_pipe();
    endtask

    task automatic stream_buffer_words();
        repeat (NUM_WORDS) step_cycle(4'hf, random_words());
        drain_pipe();
    endtask

    task automatic compare_thresholds();
        adc_words_t w;
        reg_write(2'd0, 16'd10900, 0);
        reg_write(2'd1, 16'd11200, 0);
        repeat (NUM_WORDS) step_cycle(4'hf, random_words());
        drain_pipe();
        // Beam 0 exactly at threshold, beam 1 one above
        w = random_words();
        reg_write(2'd0, reg_data_t'(model_power(w, 0)), 0);
        reg_write(2'd1, reg_data_t'(model_power(w, 1) - 1), 0);
        step_cycle(4'hf, w);
        drain_pipe();
    endtask

    task automatic reject_partial_valid();
        for (int c = 0; c < 4; c++) begin
            step_cycle(4'hf & ~(4'h1 << c), random_words());
            step_cycle(4'hf, random_words());
        end
        drain_pipe();
    endtask

    task automatic verify_count_readback();
        reg_data_t rd;
        reg_read(2'd2, rd);
        check_value("count0", 128'(rd), 128'(model_count[0]));
        reg_read(2'd3, rd);
        check_value("count1", 128'(rd), 128'(model_count[1]));
        // Long req hold, clears beam 0 only
        reg_write(2'd2, 16'h0000, 3);
        reg_read(2'd2, rd);
        check_value("count0", 128'(rd), 128'(16'h0000));
        reg_read(2'd3, rd);
        check_value("count1", 128'(rd), 128'(model_count[1]));
    endtask

    initial begin
        arst_n     = 1'b0;
        adc_tdata  = '0;
        adc_tvalid = '0;
        req        = 1'b0;
        we         = 1'b0;
        addr       = '0;
        wdata      = '0;
        for (int s = 0; s < 4; s++) begin
            exp_valid[s] = 1'b0;
            exp_trig[s]  = 2'b00;
            exp_buf[s]   = '0;
        end
        model_count[0]  = 0;
        model_count[1]  = 0;
        model_thresh[0] = 16'hffff;
        model_thresh[1] = 16'hffff;
        repeat (2) @(posedge aclk);
        #1;
        arst_n = 1'b1;
        check_after_reset();
        stream_buffer_words();
        compare_thresholds();
        reject_partial_valid();
        verify_count_readback();
        $display(">>> PASS");
        $finish;
    end

endmodule

// ==== verilog.f ====
logic/l1_trig_pkg.sv
logic/adc_unpack.sv
logic/beam_power.sv
logic/trigger_result.sv
logic/trig_ctrl_regs.sv
logic/l1_trigger_top.sv
verif/l1_trigger_tb.sv
